/* src/alu_pkg.sv */
package alu_pkg;

   // ALU operation codes, code 14 is left unused
   typedef enum logic [4:0] {
      op_add = 5'd0,
      op_adc = 5'd1,
      op_sub = 5'd2,
      op_sbb = 5'd3,
      op_inc = 5'd4,
      op_dec = 5'd5,
      op_and = 5'd6,
      op_or  = 5'd7,
      op_xor = 5'd8,
      op_shl = 5'd9,
      op_shr = 5'd10,
      op_rol = 5'd11,
      op_ror = 5'd12,
      op_mul = 5'd13,
      op_cmp = 5'd15,
      op_sha = 5'd16,
      op_stc = 5'd17,
      op_clc = 5'd18,
      op_muh = 5'd19
   } alu_op_e;

   // status word, carry in the msb
   typedef struct packed {
      logic c;
      logic v;
      logic z;
      logic s;
   } alu_flags_t;

endpackage

/* src/alu_if.sv */
`timescale 1ns/100ps

interface alu_if #(
   parameter int width = 8
);
   import alu_pkg::*;

   alu_op_e          op;
   logic [width-1:0] a;
   logic [width-1:0] b;
   alu_flags_t       flags_in;
   logic [width-1:0] res;
   alu_flags_t       flags_out;

   modport exec (
      output op,
      output a,
      output b,
      output flags_in,
      input  res,
      input  flags_out
   );

   modport alu (
      input  op,
      input  a,
      input  b,
      input  flags_in,
      output res,
      output flags_out
   );

endinterface

/* src/adder.sv */
`timescale 1ns/100ps

module adder #(
   parameter int width = 8
) (
   input  logic             ci,
   input  logic [width-1:0] ai,
   input  logic [width-1:0] bi,
   output logic [width-1:0] res,
   output logic             co,
   output logic             vo
);

   logic [width:0] sum;

   // one extra bit catches the carry out
   assign sum = {1'b0, ai} + {1'b0, bi} + {{width{1'b0}}, ci};
   assign res = sum[width-1:0];
   assign co  = sum[width];

   // operands agree in sign but the result does not
   assign vo = (ai[width-1] == bi[width-1]) && (res[width-1] != ai[width-1]);

endmodule

/* src/alu.sv */
`timescale 1ns/100ps

module alu #(
   parameter int width = 8
) (
   alu_if.alu bus
);
   import alu_pkg::*;

   logic                 cin;
   logic [width-1:0]     op2;
   logic [width-1:0]     ares;
   logic                 aco;
   logic                 avo;
   logic [2*width-1:0]   mres;
   logic [width-1:0]     res_sel;
   logic                 shift_co;
   logic                 is_arith;
   logic                 is_mult;
   logic                 is_logic;
   logic                 is_shift;
   logic                 is_carry;

   // carry-in for the adder
   always_comb begin
      case (bus.op)
         op_add, op_dec: cin = 1'b0;
         op_sub, op_cmp, op_inc: cin = 1'b1;
         default: cin = bus.flags_in.c;
      endcase
   end

   // second adder operand
   always_comb begin
      case (bus.op)
         op_sub, op_sbb, op_cmp: op2 = ~bus.b;
         op_inc: op2 = '0;
         op_dec: op2 = '1;
         default: op2 = bus.b;
      endcase
   end

   adder #(.width(width)) adder_i (
      .ci  (cin),
      .ai  (bus.a),
      .bi  (op2),
      .res (ares),
      .co  (aco),
      .vo  (avo)
   );

   // full double-width product
   assign mres = {{width{1'b0}}, bus.a} * {{width{1'b0}}, bus.b};

   // operation classes
   assign is_arith = bus.op inside {op_add, op_adc, op_sub, op_sbb, op_inc, op_dec, op_cmp};
   assign is_mult  = bus.op inside {op_mul, op_muh};
   assign is_logic = bus.op inside {op_and, op_or, op_xor};
   assign is_shift = bus.op inside {op_shl, op_shr, op_sha, op_rol, op_ror};
   assign is_carry = bus.op inside {op_stc, op_clc};

   always_comb begin
      case (bus.op)
         op_add, op_adc, op_sub, op_sbb,
         op_inc, op_dec, op_cmp: res_sel = ares;
         op_and: res_sel = bus.a & bus.b;
         op_or:  res_sel = bus.a | bus.b;
         op_xor: res_sel = bus.a ^ bus.b;
         op_shl: res_sel = {bus.a[width-2:0], 1'b0};
         op_shr: res_sel = {1'b0, bus.a[width-1:1]};
         op_sha: res_sel = {bus.a[width-1], bus.a[width-1:1]};
         op_rol: res_sel = {bus.a[width-2:0], bus.flags_in.c};
         op_ror: res_sel = {bus.flags_in.c, bus.a[width-1:1]};
         op_mul: res_sel = mres[width-1:0];
         op_muh: res_sel = mres[2*width-1:width];
         // stc, clc pass a through
         default: res_sel = bus.a;
      endcase
   end

   assign bus.res = res_sel;

   // left moves shift out the msb, right moves the lsb
   assign shift_co = (bus.op inside {op_shl, op_rol}) ? bus.a[width-1] : bus.a[0];

   always_comb begin
      bus.flags_out = bus.flags_in;
      if (is_arith) begin
         bus.flags_out.c = aco;
         bus.flags_out.v = avo;
         bus.flags_out.z = ~|res_sel;
         bus.flags_out.s = res_sel[width-1];
      end else if (is_mult) begin
         bus.flags_out.z = ~|res_sel;
         bus.flags_out.s = res_sel[width-1];
      end else if (is_logic) begin
         bus.flags_out.z = ~|res_sel;
      end else if (is_shift) begin
         bus.flags_out.c = shift_co;
         bus.flags_out.z = ~|res_sel;
      end else if (is_carry) begin
         bus.flags_out.c = (bus.op == op_stc);
      end
   end

endmodule

/* src/reg_file.sv */
`timescale 1ns/100ps

module reg_file #(
   parameter int width = 8,
   parameter int nregs = 8,
   localparam int aw = $clog2(nregs)
) (
   input  logic             clk,
   input  logic             rst,
   input  logic [aw-1:0]    ra_addr,
   input  logic [aw-1:0]    rb_addr,
   output logic [width-1:0] ra_data,
   output logic [width-1:0] rb_data,
   input  logic             we,
   input  logic [aw-1:0]    wa,
   input  logic [width-1:0] wd
);

   logic [width-1:0] regs [nregs];

   // two independent read ports
   assign ra_data = regs[ra_addr];
   assign rb_data = regs[rb_addr];

   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < nregs; i++) begin
            regs[i] <= '0;
         end
      end else if (we) begin
         regs[wa] <= wd;
      end
   end

endmodule

/* src/exec_stage.sv */
`timescale 1ns/100ps

module exec_stage #(
   parameter int width = 8,
   parameter int nregs = 8,
   localparam int aw = $clog2(nregs)
) (
   input  logic                clk,
   input  logic                rst,
   input  logic                issue,
   input  alu_pkg::alu_op_e    op,
   input  logic [aw-1:0]       rd,
   input  logic [aw-1:0]       ra,
   input  logic [aw-1:0]       rb,
   input  logic                load,
   input  logic [aw-1:0]       load_addr,
   input  logic [width-1:0]    load_data,
   output logic [aw-1:0]       ra_addr,
   output logic [aw-1:0]       rb_addr,
   input  logic [width-1:0]    ra_data,
   input  logic [width-1:0]    rb_data,
   output logic                we,
   output logic [aw-1:0]       wa,
   output logic [width-1:0]    wd,
   alu_if.exec                 bus,
   output logic                res_valid,
   output logic [width-1:0]    res,
   output alu_pkg::alu_flags_t flags
);
   import alu_pkg::*;

   logic writes_rd;

   assign ra_addr = ra;
   assign rb_addr = rb;

   assign bus.op       = op;
   assign bus.a        = ra_data;
   assign bus.b        = rb_data;
   assign bus.flags_in = flags;

   // compare and carry ops only touch the status
   assign writes_rd = !(op inside {op_cmp, op_stc, op_clc});

   // issue owns the write port, a colliding load is lost
   assign we = issue ? writes_rd : load;
   assign wa = issue ? rd : load_addr;
   assign wd = issue ? bus.res : load_data;

   always_ff @(posedge clk) begin
      if (rst) begin
         res_valid <= 1'b0;
         res       <= '0;
         flags     <= '0;
      end else begin
         res_valid <= issue;
         if (issue) begin
            res   <= bus.res;
            flags <= bus.flags_out;
         end
      end
   end

endmodule

/* src/exec_top.sv */
`timescale 1ns/100ps

module exec_top #(
   parameter int width = 8,
   parameter int nregs = 8,
   localparam int aw = $clog2(nregs)
) (
   input  logic                clk,
   input  logic                rst,
   input  logic                issue,
   input  alu_pkg::alu_op_e    op,
   input  logic [aw-1:0]       rd,
   input  logic [aw-1:0]       ra,
   input  logic [aw-1:0]       rb,
   input  logic                load,
   input  logic [aw-1:0]       load_addr,
   input  logic [width-1:0]    load_data,
   output logic                res_valid,
   output logic [width-1:0]    res,
   output alu_pkg::alu_flags_t flags
);

   logic [aw-1:0]    ra_addr;
   logic [aw-1:0]    rb_addr;
   logic [width-1:0] ra_data;
   logic [width-1:0] rb_data;
   logic             we;
   logic [aw-1:0]    wa;
   logic [width-1:0] wd;

   alu_if #(.width(width)) alu_bus ();

   reg_file #(.width(width), .nregs(nregs)) reg_file_i (
      .clk     (clk),
      .rst     (rst),
      .ra_addr (ra_addr),
      .rb_addr (rb_addr),
      .ra_data (ra_data),
      .rb_data (rb_data),
      .we      (we),
      .wa      (wa),
      .wd      (wd)
   );

   exec_stage #(.width(width), .nregs(nregs)) exec_stage_i (
      .clk       (clk),
      .rst       (rst),
      .issue     (issue),
      .op        (op),
      .rd        (rd),
      .ra        (ra),
      .rb        (rb),
      .load      (load),
      .load_addr (load_addr),
      .load_data (load_data),
      .ra_addr   (ra_addr),
      .rb_addr   (rb_addr),
      .ra_data   (ra_data),
      .rb_data   (rb_data),
      .we        (we),
      .wa        (wa),
      .wd        (wd),
      .bus       (alu_bus),
      .res_valid (res_valid),
      .res       (res),
      .flags     (flags)
   );

   alu #(.width(width)) alu_i (
      .bus (alu_bus)
   );

endmodule

/* verif/exec_sva.sv */
`timescale 1ns/100ps

module exec_sva (
   input logic                clk,
   input logic                rst,
   input logic                issue,
   input logic                res_valid,
   input alu_pkg::alu_flags_t flags
);

   // result strobe one cycle after issue
   a_valid_after_issue: assert property (
      @(posedge clk) disable iff (rst) issue |=> res_valid
   ) else $error("res_valid missing one cycle after issue");

   a_no_valid_without_issue: assert property (
      @(posedge clk) disable iff (rst) !issue |=> !res_valid
   ) else $error("res_valid raised without a prior issue");

   a_reset_clears_valid: assert property (
      @(posedge clk) rst |=> !res_valid
   ) else $error("res_valid high after reset");

   // status only moves on an issued instruction
   a_flags_hold: assert property (
      @(posedge clk) disable iff (rst) !issue |=> $stable(flags)
   ) else $error("flags changed without a prior issue");

endmodule

/* verif/exec_tb.sv */
`timescale 1ns/100ps

module exec_tb;
   import alu_pkg::*;

   localparam int width = 8;
   localparam int nregs = 8;
   localparam int aw = $clog2(nregs);
   localparam int ntests = 23;
   localparam int test_cycles = 8;

   typedef struct packed {
      alu_op_e       op;
      logic [aw-1:0] ra;
      logic [aw-1:0] rb;
      logic [aw-1:0] rd;
      logic          cset;
      logic          ld;
   } test_t;

   // op, ra, rb, rd, carry before the op, preload of ra and rb
   test_t tests [ntests] = '{
      '{op_or,  3'd0, 3'd7, 3'd0, 1'b0, 1'b0},
      '{op_add, 3'd1, 3'd2, 3'd3, 1'b1, 1'b1},
      '{op_adc, 3'd1, 3'd2, 3'd3, 1'b1, 1'b1},
      '{op_sub, 3'd1, 3'd2, 3'd4, 1'b0, 1'b1},
      '{op_sbb, 3'd1, 3'd2, 3'd4, 1'b0, 1'b1},
      '{op_sub, 3'd1, 3'd1, 3'd4, 1'b0, 1'b1},
      '{op_inc, 3'd5, 3'd5, 3'd5, 1'b0, 1'b1},
      '{op_dec, 3'd5, 3'd5, 3'd6, 1'b1, 1'b1},
      '{op_cmp, 3'd1, 3'd2, 3'd3, 1'b0, 1'b1},
      '{op_or,  3'd3, 3'd3, 3'd4, 1'b1, 1'b0},
      '{op_and, 3'd1, 3'd2, 3'd4, 1'b1, 1'b1},
      '{op_or,  3'd1, 3'd2, 3'd4, 1'b0, 1'b1},
      '{op_xor, 3'd1, 3'd2, 3'd4, 1'b1, 1'b1},
      '{op_mul, 3'd1, 3'd2, 3'd5, 1'b1, 1'b1},
      '{op_muh, 3'd1, 3'd2, 3'd6, 1'b0, 1'b1},
      '{op_shl, 3'd1, 3'd2, 3'd3, 1'b0, 1'b1},
      '{op_shr, 3'd1, 3'd2, 3'd3, 1'b1, 1'b1},
      '{op_sha, 3'd1, 3'd2, 3'd3, 1'b0, 1'b1},
      '{op_rol, 3'd1, 3'd2, 3'd3, 1'b1, 1'b1},
      '{op_ror, 3'd1, 3'd2, 3'd3, 1'b1, 1'b1},
      '{op_ror, 3'd1, 3'd2, 3'd3, 1'b0, 1'b1},
      '{op_stc, 3'd1, 3'd2, 3'd3, 1'b0, 1'b1},
      '{op_clc, 3'd1, 3'd2, 3'd3, 1'b1, 1'b1}
   };
   string names [ntests] = '{
      "reset regs", "add", "adc", "sub", "sbb", "sub zero", "inc", "dec", "cmp",
      "cmp keeps rd", "and", "or", "xor", "mul", "muh", "shl", "shr", "sha", "rol",
      "ror c1", "ror c0", "stc", "clc"
   };

   logic             clk = 1'b0;
   logic             rst;
   logic             issue;
   alu_op_e          op;
   logic [aw-1:0]    rd;
   logic [aw-1:0]    ra;
   logic [aw-1:0]    rb;
   logic             load;
   logic [aw-1:0]    load_addr;
   logic [width-1:0] load_data;
   logic             res_valid;
   logic [width-1:0] res;
   alu_flags_t       flags;

   logic [31:0]      lfsr = 32'hfad6;
   logic [width-1:0] model_regs [nregs];
   alu_flags_t       model_flags;
   logic [width-1:0] er;
   alu_flags_t       ef;
   int               data_errors = 0;
   int               flag_errors = 0;
   int               protocol_errors = 0;

   exec_top #(.width(width), .nregs(nregs)) dut_i (
      .clk       (clk),
      .rst       (rst),
      .issue     (issue),
      .op        (op),
      .rd        (rd),
      .ra        (ra),
      .rb        (rb),
      .load      (load),
      .load_addr (load_addr),
      .load_data (load_data),
      .res_valid (res_valid),
      .res       (res),
      .flags     (flags)
   );

   bind exec_stage exec_sva sva_i (
      .clk       (clk),
      .rst       (rst),
      .issue     (issue),
      .res_valid (res_valid),
      .flags     (flags)
   );

   always #10 clk = ~clk;

   // taps 32, 22, 2, 1
   function automatic logic lfsr_bit();
      logic fb;
      fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      return fb;
   endfunction

   function automatic logic [width-1:0] rand_word();
      logic [width-1:0] v;
      v = '0;
      for (int i = 0; i < width; i++) begin
         v = {v[width-2:0], lfsr_bit()};
      end
      return v;
   endfunction

   // reference behavior of one instruction
   task automatic model_op(input alu_op_e code, input logic [width-1:0] a,
                           input logic [width-1:0] b, input alu_flags_t fi,
                           output logic [width-1:0] r, output alu_flags_t fo);
      logic [width:0]     sum;
      logic [width-1:0]   bop;
      logic [2*width-1:0] prod;
      logic               cin;
      int                 ssum;
      fo = fi;
      bop = b;
      cin = 1'b0;
      prod = (2*width)'(a) * (2*width)'(b);
      case (code)
         op_adc: cin = fi.c;
         op_sub, op_cmp: begin
            bop = ~b;
            cin = 1'b1;
         end
         op_sbb: begin
            bop = ~b;
            cin = fi.c;
         end
         op_inc: begin
            bop = '0;
            cin = 1'b1;
         end
         op_dec: bop = '1;
         default: ;
      endcase
      sum = {1'b0, a} + {1'b0, bop} + {{width{1'b0}}, cin};
      ssum = int'($signed(a)) + int'($signed(bop)) + int'(cin);
      r = a;
      case (code)
         op_add, op_adc, op_sub, op_sbb, op_inc, op_dec, op_cmp: begin
            r = sum[width-1:0];
            fo.c = sum[width];
            fo.v = (ssum > 2**(width-1) - 1) || (ssum < -(2**(width-1)));
         end
         op_and: r = a & b;
         op_or:  r = a | b;
         op_xor: r = a ^ b;
         op_mul: r = prod[width-1:0];
         op_muh: r = prod[2*width-1:width];
         op_shl: r = a << 1;
         op_shr: r = a >> 1;
         op_sha: r = $signed(a) >>> 1;
         op_rol: r = {a[width-2:0], fi.c};
         op_ror: r = {fi.c, a[width-1:1]};
         default: ;
      endcase
      if (code inside {op_shl, op_rol}) fo.c = a[width-1];
      if (code inside {op_shr, op_sha, op_ror}) fo.c = a[0];
      if (code inside {op_stc, op_clc}) fo.c = (code == op_stc);
      else fo.z = (r == '0);
      if (code inside {op_add, op_adc, op_sub, op_sbb, op_inc, op_dec, op_cmp, op_mul, op_muh})
         fo.s = r[width-1];
   endtask

   task automatic check_data(input string name, input logic [width-1:0] exp,
                             input logic [width-1:0] act);
      if (act !== exp) begin
         data_errors++;
         $display("error %s: res expected %h, actual %h", name, exp, act);
      end
   endtask

   task automatic check_flags(input string name, input alu_flags_t exp, input alu_flags_t act);
      if (act !== exp) begin
         flag_errors++;
         $display("error %s: flags cvzs expected %b, actual %b", name, exp, act);
      end
   endtask

   task automatic check_result(input string name, input logic [width-1:0] exp_res,
                               input alu_flags_t exp_flags);
      if (res_valid !== 1'b1) begin
         protocol_errors++;
         $display("%s: res_valid was not high one cycle after the issue", name);
      end
      check_data(name, exp_res, res);
      check_flags(name, exp_flags, flags);
   endtask

   task automatic load_reg(input logic [aw-1:0] addr, input logic [width-1:0] data);
      load = 1'b1;
      load_addr = addr;
      load_data = data;
      model_regs[addr] = data;
      @(negedge clk);
      load = 1'b0;
   endtask

   // drives one issue cycle and advances the model
   task automatic drive_issue(input alu_op_e code, input logic [aw-1:0] src_a,
                              input logic [aw-1:0] src_b, input logic [aw-1:0] dest,
                              output logic [width-1:0] r, output alu_flags_t f);
      issue = 1'b1;
      op = code;
      ra = src_a;
      rb = src_b;
      rd = dest;
      model_op(code, model_regs[src_a], model_regs[src_b], model_flags, r, f);
      model_flags = f;
      if (!(code inside {op_cmp, op_stc, op_clc})) model_regs[dest] = r;
   endtask

   task automatic run_test(input int idx);
      test_t   t;
      alu_op_e setup;
      t = tests[idx];
      setup = op_clc;
      if (t.cset) setup = op_stc;
      if (t.ld) begin
         load_reg(t.ra, rand_word());
         load_reg(t.rb, rand_word());
      end
      // carry setup and the op under test go back to back
      drive_issue(setup, t.ra, t.rb, t.rd, er, ef);
      @(negedge clk);
      check_result({names[idx], " setup"}, er, ef);
      drive_issue(t.op, t.ra, t.rb, t.rd, er, ef);
      @(negedge clk);
      issue = 1'b0;
      check_result(names[idx], er, ef);
      @(negedge clk);
      if (res_valid !== 1'b0) begin
         protocol_errors++;
         $display("%s: res_valid stayed high for more than one cycle", names[idx]);
      end
   endtask

   initial begin
      #((ntests + 10) * test_cycles * 20);
      $display("timeout: the test sequence did not finish in time");
      $display(">>> FAIL");
      $finish;
   end

   initial begin
      rst = 1'b1;
      issue = 1'b0;
      op = op_add;
      rd = '0;
      ra = '0;
      rb = '0;
      load = 1'b0;
      load_addr = '0;
      load_data = '0;
      model_flags = '0;
      foreach (model_regs[i]) model_regs[i] = '0;
      repeat (5) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
      if (res_valid !== 1'b0) begin
         protocol_errors++;
         $display("res_valid is high right after reset");
      end
      check_data("reset res", '0, res);
      check_flags("reset flags", '0, flags);
      for (int i = 0; i < ntests; i++) begin
         run_test(i);
      end
      // a load that collides with an issue must be lost
      load_reg(3'd7, rand_word());
      load = 1'b1;
      load_addr = 3'd7;
      load_data = ~model_regs[7];
      drive_issue(op_cmp, 3'd0, 3'd1, 3'd2, er, ef);
      @(negedge clk);
      load = 1'b0;
      check_result("collision cmp", er, ef);
      drive_issue(op_or, 3'd7, 3'd7, 3'd6, er, ef);
      @(negedge clk);
      issue = 1'b0;
      check_result("collision readback", er, ef);
      $display("errors: data %0d, flags %0d, protocol %0d",
               data_errors, flag_errors, protocol_errors);
      if (data_errors + flag_errors + protocol_errors == 0) begin
         $display(">>> PASS");
      end else begin
         $display(">>> FAIL");
      end
      $finish;
   end

endmodule

/* project.f */
src/alu_pkg.sv
src/alu_if.sv
src/adder.sv
src/alu.sv
src/reg_file.sv
src/exec_stage.sv
src/exec_top.sv
verif/exec_sva.sv
verif/exec_tb.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f project.f --top-module exec_tb \
   -Mdir obj_dir -o exec_sim
status=$?
if [ $status -ne 0 ]; then
   echo "verilator build failed with status $status"
   exit 1
fi

output=$(./obj_dir/exec_sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if printf '%s\n' "$output" | grep -qx '>>> PASS'; then
   exit 0
fi
exit 1
